//--- src/edgeDetect_params.svh
`ifndef EDGE_DETECT_PARAMS_SVH
`define EDGE_DETECT_PARAMS_SVH

// image geometry
`define IMG_WIDTH 18   // pixels per line

// kernel
`define EDGE_THRESH 32 // difference must exceed this

// output stream
`define CREDIT_MAX 4   // credits held by the sink

// measurement counters
`define COUNT_BITS 11  // pixels per line and lines per frame

`endif

//--- src/edgePkg.sv
`include "edgeDetect_params.svh"

package edgePkg;

  typedef logic [7:0] grayPixel;                 // 8-bit luminance
  typedef logic [`COUNT_BITS-1:0] measCount;     // line and frame measurements

  // neighbourhood of one interior column
  typedef struct packed {
    grayPixel up;     // oldest row
    grayPixel right;  // middle row, column + 1
    grayPixel down;   // newest row
    grayPixel left;   // middle row, column - 1
  } kernelWindow;

  typedef struct packed {
    logic dx;  // horizontal gradient over threshold
    logic dy;  // vertical gradient over threshold
  } edgeFlags;

  typedef enum logic [1:0] {
    opReadPixels  = 2'd0,
    opReadLines   = 2'd1,
    opSetEnable   = 2'd2,
    opReadOverrun = 2'd3  // read and clear
  } cmdOpType;

  typedef enum logic {
    packIdle = 1'b0,
    packSend = 1'b1
  } packState;

endpackage

//--- src/pixelIf.sv
`timescale 1ns/1ns

interface pixelIf;
  import edgePkg::*;

  logic     pixValid;  // one pulse per completed pixel
  grayPixel gray;
  measCount column;    // index within the line
  logic     lineEnd;   // hsync fell
  logic     frameEnd;  // vsync fell

  modport source (
    output pixValid, gray, column, lineEnd, frameEnd
  );

  modport sink (
    input pixValid, gray, column, lineEnd, frameEnd
  );

endinterface

//--- src/cameraCapture.sv
`timescale 1ns/1ns

module cameraCapture (
  input  logic              pclk,
  input  logic              rst,
  input  logic              hsync,
  input  logic              vsync,
  input  logic [7:0]        camData,
  pixelIf.source            pix,
  output edgePkg::measCount pixelsPerLine,
  output edgePkg::measCount linesPerFrame
);
  import edgePkg::*;

  logic       hsyncReg;
  logic       vsyncReg;
  logic       hsyncFall;
  logic       vsyncFall;
  logic       bytePhase;  // high once the first byte of a pair is held
  logic [7:0] highByte;   // rgb565 bits 15..8
  logic [15:0] rgb;
  logic [9:0] graySum;
  measCount   pixCount;
  measCount   lineCount;

  assign hsyncFall = hsyncReg & ~hsync;
  assign vsyncFall = vsyncReg & ~vsync;
  assign rgb       = {highByte, camData};

  // r8 + 2*g8 + b8, max 1000 so 10 bits suffice
  assign graySum = {2'b00, rgb[15:11], 3'b000}
                 + {1'b0, rgb[10:5], 3'b000}
                 + {2'b00, rgb[4:0], 3'b000};

  always_ff @(posedge pclk) begin
    if (rst) begin
      hsyncReg      <= 1'b0;
      vsyncReg      <= 1'b0;
      bytePhase     <= 1'b0;
      pixCount      <= '0;
      lineCount     <= '0;
      pixelsPerLine <= '0;
      linesPerFrame <= '0;
      pix.pixValid  <= 1'b0;
      pix.lineEnd   <= 1'b0;
      pix.frameEnd  <= 1'b0;
    end else begin
      hsyncReg     <= hsync;
      vsyncReg     <= vsync;
      pix.lineEnd  <= hsyncFall;
      pix.frameEnd <= vsyncFall;
      pix.pixValid <= hsync & bytePhase;  // second byte sampled now
      if (hsync) begin
        bytePhase <= ~bytePhase;
        if (bytePhase) begin
          pixCount <= pixCount + 1'b1;
        end
      end else begin
        bytePhase <= 1'b0;  // realign pairs on every line
        if (hsyncFall) begin
          pixelsPerLine <= pixCount;  // bytes / 2
          pixCount      <= '0;
        end
      end
      if (vsyncFall) begin
        linesPerFrame <= lineCount;
        lineCount     <= '0;
      end else if (hsyncFall) begin
        lineCount <= lineCount + 1'b1;
      end
    end
  end

  // pixel payload
  always_ff @(posedge pclk) begin
    if (hsync && !bytePhase) begin
      highByte <= camData;
    end
    if (hsync && bytePhase) begin
      pix.gray   <= graySum[9:2];
      pix.column <= pixCount;
    end
  end

  // both bytes of a pixel were taken inside the active line
  assert property (@(posedge pclk) disable iff (rst)
    pix.pixValid |-> $past(hsync, 1) && $past(hsync, 2));

endmodule

//--- src/lineStrip.sv
`timescale 1ns/1ns
`include "edgeDetect_params.svh"

module lineStrip (
  input  logic                 pclk,
  input  logic                 rst,
  pixelIf.sink                 pix,
  output edgePkg::kernelWindow windows [1:`IMG_WIDTH-2],
  output logic                 lineReady
);
  import edgePkg::*;

  localparam int COL_BITS = $clog2(`IMG_WIDTH);

  grayPixel   rowTop [0:`IMG_WIDTH-1];  // oldest line
  grayPixel   rowMid [0:`IMG_WIDTH-1];
  grayPixel   rowNew [0:`IMG_WIDTH-1];  // line being received
  logic [1:0] linesSeen;                // saturates at 2
  logic       colInRange;

  assign colInRange = pix.column < measCount'(`IMG_WIDTH);

  // third and later line ends of a frame have a full strip
  assign lineReady = pix.lineEnd && (linesSeen == 2'd2);

  always_ff @(posedge pclk) begin
    if (rst) begin
      linesSeen <= 2'd0;
    end else if (pix.frameEnd) begin
      linesSeen <= 2'd0;
    end else if (pix.lineEnd && linesSeen != 2'd2) begin
      linesSeen <= linesSeen + 2'd1;
    end
  end

  // strip storage
  always_ff @(posedge pclk) begin
    if (pix.pixValid && colInRange) begin
      rowNew[pix.column[COL_BITS-1:0]] <= pix.gray;
    end
    if (pix.lineEnd) begin
      rowTop <= rowMid;  // scroll up one line
      rowMid <= rowNew;
    end
  end

  always_comb begin
    for (int c = 1; c <= `IMG_WIDTH-2; c++) begin
      windows[c].up    = rowTop[c];
      windows[c].right = rowMid[c+1];
      windows[c].down  = rowNew[c];
      windows[c].left  = rowMid[c-1];
    end
  end

endmodule

//--- src/edgeKernel.sv
`timescale 1ns/1ns
`include "edgeDetect_params.svh"

module edgeKernel (
  input  edgePkg::kernelWindow window,
  output edgePkg::edgeFlags    flags
);
  import edgePkg::*;

  grayPixel diffX;  // |right - left|
  grayPixel diffY;  // |up - down|

  assign diffX = (window.right > window.left) ? window.right - window.left
                                              : window.left - window.right;
  assign diffY = (window.up > window.down) ? window.up - window.down
                                           : window.down - window.up;

  // strictly greater than the threshold
  assign flags.dx = diffX > grayPixel'(`EDGE_THRESH);
  assign flags.dy = diffY > grayPixel'(`EDGE_THRESH);

endmodule

//--- src/edgePacker.sv
`timescale 1ns/1ns
`include "edgeDetect_params.svh"

module edgePacker (
  input  logic              pclk,
  input  logic              rst,
  input  logic              lineReady,
  input  logic              enable,
  input  logic              overrunClear,
  input  edgePkg::edgeFlags flags [1:`IMG_WIDTH-2],
  output logic              outValid,
  output logic [7:0]        outData,
  input  logic              outCredit,
  output logic              overrun
);
  import edgePkg::*;

  localparam int NUM_BYTES   = `IMG_WIDTH / 4;
  localparam int LINE_BITS   = NUM_BYTES * 8;
  localparam int USED_COLS   = (NUM_BYTES * 4 < `IMG_WIDTH - 2) ? NUM_BYTES * 4 : `IMG_WIDTH - 2;
  localparam int CREDIT_BITS = $clog2(`CREDIT_MAX + 1);
  localparam int BYTE_BITS   = $clog2(NUM_BYTES + 1);

  packState               state;
  logic [LINE_BITS-1:0]   packedLine;  // flags of the current kernels
  logic [LINE_BITS-1:0]   lineBits;    // captured line, next byte on top
  logic [BYTE_BITS-1:0]   bytesLeft;
  logic [CREDIT_BITS-1:0] credits;
  logic                   capture;
  logic                   lineDrop;

  // column 1 lands in the two top bits of byte 0
  always_comb begin
    packedLine = '0;
    for (int c = 1; c <= USED_COLS; c++) begin
      packedLine[LINE_BITS-2*c +: 2] = {flags[c].dx, flags[c].dy};
    end
  end

  assign capture  = lineReady && enable && (state == packIdle);
  assign lineDrop = lineReady && enable && (state == packSend);  // previous line still draining
  assign outValid = (state == packSend) && (credits != '0);
  assign outData  = lineBits[LINE_BITS-1 -: 8];

  always_ff @(posedge pclk) begin
    if (rst) begin
      state     <= packIdle;
      bytesLeft <= '0;
      credits   <= CREDIT_BITS'(`CREDIT_MAX);
      overrun   <= 1'b0;
    end else begin
      credits <= credits + CREDIT_BITS'(outCredit) - CREDIT_BITS'(outValid);
      case (state)
        packIdle: begin
          if (capture) begin
            state     <= packSend;
            bytesLeft <= BYTE_BITS'(NUM_BYTES);
          end
        end
        packSend: begin
          if (outValid) begin
            bytesLeft <= bytesLeft - 1'b1;
            if (bytesLeft == BYTE_BITS'(1)) begin
              state <= packIdle;  // last byte of the line
            end
          end
        end
      endcase
      if (lineDrop) begin
        overrun <= 1'b1;  // a new event wins over a clear
      end else if (overrunClear) begin
        overrun <= 1'b0;
      end
    end
  end

  // line payload
  always_ff @(posedge pclk) begin
    if (capture) begin
      lineBits <= packedLine;
    end else if (outValid) begin
      lineBits <= lineBits << 8;
    end
  end

  // the sink never returns more credits than it was given
  assert property (@(posedge pclk) disable iff (rst)
    credits <= CREDIT_BITS'(`CREDIT_MAX));

  // with no credit the packer holds its byte and waits
  assert property (@(posedge pclk) disable iff (rst)
    state == packSend && credits == '0 |=> state == packSend && $stable(outData));

endmodule

//--- src/controlRegs.sv
`timescale 1ns/1ns

module controlRegs (
  input  logic              pclk,
  input  logic              rst,
  input  logic              cmdValid,
  input  edgePkg::cmdOpType cmdOp,
  input  logic [31:0]       cmdData,
  input  edgePkg::measCount pixelsPerLine,
  input  edgePkg::measCount linesPerFrame,
  input  logic              overrun,
  output logic              enable,
  output logic              overrunClear,
  output logic [31:0]       cmdResult,
  output logic              cmdDone
);
  import edgePkg::*;

  logic [31:0] selResult;

  assign cmdDone      = cmdValid;  // every command finishes in one cycle
  assign overrunClear = cmdValid && (cmdOp == opReadOverrun);
  assign cmdResult    = cmdValid ? selResult : 32'd0;

  always_comb begin
    case (cmdOp)
      opReadPixels:  selResult = 32'(pixelsPerLine);
      opReadLines:   selResult = 32'(linesPerFrame);
      opSetEnable:   selResult = {31'd0, enable};
      opReadOverrun: selResult = {31'd0, overrun};
      default:       selResult = 32'd0;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      enable <= 1'b0;  // output off until enabled
    end else if (cmdValid && cmdOp == opSetEnable) begin
      enable <= cmdData[0];
    end
  end

endmodule

//--- src/edgeDetect.sv
`timescale 1ns/1ns
`include "edgeDetect_params.svh"

module edgeDetect (
  input  logic              pclk,
  input  logic              rst,
  // camera
  input  logic              hsync,
  input  logic              vsync,
  input  logic [7:0]        camData,
  // command port
  input  logic              cmdValid,
  input  edgePkg::cmdOpType cmdOp,
  input  logic [31:0]       cmdData,
  output logic [31:0]       cmdResult,
  output logic              cmdDone,
  // edge byte stream
  output logic              outValid,
  output logic [7:0]        outData,
  input  logic              outCredit
);
  import edgePkg::*;

  kernelWindow windows [1:`IMG_WIDTH-2];
  edgeFlags    flags [1:`IMG_WIDTH-2];
  measCount    pixelsPerLine;
  measCount    linesPerFrame;
  logic        lineReady;
  logic        enable;
  logic        overrun;
  logic        overrunClear;

  pixelIf pixBus ();

  cameraCapture i_cameraCapture (
    .pclk          (pclk),
    .rst           (rst),
    .hsync         (hsync),
    .vsync         (vsync),
    .camData       (camData),
    .pix           (pixBus.source),
    .pixelsPerLine (pixelsPerLine),
    .linesPerFrame (linesPerFrame)
  );

  lineStrip i_lineStrip (
    .pclk      (pclk),
    .rst       (rst),
    .pix       (pixBus.sink),
    .windows   (windows),
    .lineReady (lineReady)
  );

  // one kernel per interior column
  for (genvar col = 1; col <= `IMG_WIDTH-2; col++) begin : gKernel
    edgeKernel i_edgeKernel (
      .window (windows[col]),
      .flags  (flags[col])
    );
  end

  edgePacker i_edgePacker (
    .pclk         (pclk),
    .rst          (rst),
    .lineReady    (lineReady),
    .enable       (enable),
    .overrunClear (overrunClear),
    .flags        (flags),
    .outValid     (outValid),
    .outData      (outData),
    .outCredit    (outCredit),
    .overrun      (overrun)
  );

  controlRegs i_controlRegs (
    .pclk          (pclk),
    .rst           (rst),
    .cmdValid      (cmdValid),
    .cmdOp         (cmdOp),
    .cmdData       (cmdData),
    .pixelsPerLine (pixelsPerLine),
    .linesPerFrame (linesPerFrame),
    .overrun       (overrun),
    .enable        (enable),
    .overrunClear  (overrunClear),
    .cmdResult     (cmdResult),
    .cmdDone       (cmdDone)
  );

endmodule

//--- verification/edgeDetectTb.sv
`timescale 1ns/1ns
`include "edgeDetect_params.svh"

module edgeDetectTb;
  import edgePkg::*;

  localparam int OP_FRAME   = 0;
  localparam int OP_CMD     = 1;
  localparam int OP_EXPECT  = 2;
  localparam int OP_HOLD    = 3;
  localparam int OP_RELEASE = 4;
  localparam int OP_WAIT    = 5;

  logic        pclk;
  logic        rst;
  logic        hsync;
  logic        vsync;
  logic [7:0]  camData;
  logic        cmdValid;
  cmdOpType    cmdOp;
  logic [31:0] cmdData;
  logic [31:0] cmdResult;
  logic        cmdDone;
  logic        outValid;
  logic [7:0]  outData;
  logic        outCredit;

  int          opKind [$];
  int          opCount [$];  // rows, bytes or opcode
  logic [31:0] opData [$];
  logic [31:0] opExpect [$];
  logic [15:0] pixQ [$];     // all frame pixels in file order
  logic [7:0]  expAll [$];   // all expected bytes in file order
  logic [7:0]  expQ [$];     // bytes still due on the stream
  int          returnAt [$]; // cycle at which a credit goes back
  int          cycle;
  int          limit;
  int          heldBytes;
  int          errorCount;
  bit          holdCredits;

  edgeDetect i_edgeDetect (
    .pclk      (pclk),
    .rst       (rst),
    .hsync     (hsync),
    .vsync     (vsync),
    .camData   (camData),
    .cmdValid  (cmdValid),
    .cmdOp     (cmdOp),
    .cmdData   (cmdData),
    .cmdResult (cmdResult),
    .cmdDone   (cmdDone),
    .outValid  (outValid),
    .outData   (outData),
    .outCredit (outCredit)
  );

  initial pclk = 1'b0;
  always #20 pclk = ~pclk;  // 40 ns period

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      errorCount++;
      stopWithFailure($sformatf("Error: %s got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic checkResult(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errorCount++;
      stopWithFailure($sformatf("Error: %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errorCount++;
      stopWithFailure($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // parse the tests file and size the timeout from it
  task automatic loadTests();
    int          fd;
    int          n;
    int          total;
    string       tok;
    string       rest;
    logic [31:0] val;
    logic [31:0] exp;
    total = 0;
    fd = $fopen("verification/edgeTests.txt", "r");
    if (fd == 0) begin
      stopWithFailure("could not open verification/edgeTests.txt");
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.substr(0, 0) == "#") begin
        void'($fgets(rest, fd));  // comment runs to end of line
      end else if (tok == "frame") begin
        void'($fscanf(fd, "%d", n));
        for (int i = 0; i < n * `IMG_WIDTH; i++) begin
          void'($fscanf(fd, "%h", val));
          pixQ.push_back(val[15:0]);
        end
        opKind.push_back(OP_FRAME);
        opCount.push_back(n);
        opData.push_back(32'd0);
        opExpect.push_back(32'd0);
        total += n * (2 * `IMG_WIDTH + 9) + 12;
      end else if (tok == "cmd") begin
        void'($fscanf(fd, "%d %h %h", n, val, exp));
        opKind.push_back(OP_CMD);
        opCount.push_back(n);
        opData.push_back(val);
        opExpect.push_back(exp);
        total += 3;
      end else if (tok == "expect") begin
        void'($fscanf(fd, "%d", n));
        for (int i = 0; i < n; i++) begin
          void'($fscanf(fd, "%h", val));
          expAll.push_back(val[7:0]);
        end
        opKind.push_back(OP_EXPECT);
        opCount.push_back(n);
        opData.push_back(32'd0);
        opExpect.push_back(32'd0);
        total += 4 * n;
      end else if (tok == "hold" || tok == "release" || tok == "wait") begin
        opKind.push_back(tok == "hold" ? OP_HOLD : (tok == "release" ? OP_RELEASE : OP_WAIT));
        opCount.push_back(0);
        opData.push_back(32'd0);
        opExpect.push_back(32'd0);
        total += 20;
      end else begin
        stopWithFailure($sformatf("unknown record %s in the tests file", tok));
      end
    end
    $fclose(fd);
    limit = 4 * total + 1000;
  endtask

  // one camera byte per cycle, random idle gap after each line
  task automatic sendFrame(input int rows);
    logic [15:0] px;
    int          gap;
    @(posedge pclk);
    vsync <= 1'b1;
    repeat (4) @(posedge pclk);
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < `IMG_WIDTH; c++) begin
        px = pixQ.pop_front();
        @(posedge pclk);
        hsync   <= 1'b1;
        camData <= px[15:8];
        @(posedge pclk);
        camData <= px[7:0];
      end
      @(posedge pclk);
      hsync   <= 1'b0;
      camData <= 8'd0;
      gap = 4 + ($urandom % 5);
      repeat (gap - 1) @(posedge pclk);
    end
    @(posedge pclk);
    vsync <= 1'b0;
    repeat (4) @(posedge pclk);
  endtask

  task automatic issueCommand(input int op, input logic [31:0] data, input logic [31:0] exp);
    @(posedge pclk);
    cmdValid <= 1'b1;
    cmdOp    <= cmdOpType'(op);
    cmdData  <= data;
    @(negedge pclk);
    checkResult("cmdResult", cmdResult, exp);
    @(posedge pclk);
    cmdValid <= 1'b0;
  endtask

  task automatic waitDrained();
    while (expQ.size() != 0 || returnAt.size() != 0) begin
      @(posedge pclk);
    end
    repeat (2) @(posedge pclk);
  endtask

  // stream monitor and cycle count, sampled mid-cycle
  always @(negedge pclk) begin
    logic [7:0] exp;
    cycle++;
    if (limit != 0 && cycle > limit) begin
      stopWithFailure($sformatf("timeout after %0d cycles", cycle));
    end
    if (!rst) begin
      checkFlag("cmdDone", cmdDone, cmdValid);
      if (!cmdValid) begin
        checkResult("cmdResult", cmdResult, 32'd0);  // idle port reads zero
      end
      if (outValid) begin
        if (expQ.size() == 0) begin
          stopWithFailure("a byte appeared on the stream when none was expected");
        end
        exp = expQ.pop_front();
        checkByte("outData", outData, exp);
        returnAt.push_back(cycle + 2);
        if (holdCredits) begin
          heldBytes++;
          if (heldBytes > `CREDIT_MAX) begin
            stopWithFailure("more bytes were sent than the sink had credits for");
          end
        end
      end
    end
  end

  // sink credit model
  always @(posedge pclk) begin
    if (rst) begin
      outCredit <= 1'b0;
    end else if (!holdCredits && returnAt.size() != 0 && returnAt[0] <= cycle) begin
      void'(returnAt.pop_front());
      outCredit <= 1'b1;
    end else begin
      outCredit <= 1'b0;
    end
  end

  initial begin
    rst         = 1'b1;
    hsync       = 1'b0;
    vsync       = 1'b0;
    camData     = 8'd0;
    cmdValid    = 1'b0;
    cmdOp       = opReadPixels;
    cmdData     = 32'd0;
    outCredit   = 1'b0;
    cycle       = 0;
    limit       = 0;
    heldBytes   = 0;
    errorCount  = 0;
    holdCredits = 1'b0;
    void'($urandom(12));  // seeds the generator once
    loadTests();
    repeat (3) @(posedge pclk);
    rst <= 1'b0;
    repeat (2) @(posedge pclk);
    foreach (opKind[i]) begin
      case (opKind[i])
        OP_FRAME:   sendFrame(opCount[i]);
        OP_CMD:     issueCommand(opCount[i], opData[i], opExpect[i]);
        OP_EXPECT: begin
          for (int k = 0; k < opCount[i]; k++) begin
            expQ.push_back(expAll.pop_front());
          end
        end
        OP_HOLD: begin
          @(posedge pclk);
          heldBytes = 0;
          holdCredits <= 1'b1;
        end
        OP_RELEASE: begin
          @(posedge pclk);
          holdCredits <= 1'b0;
        end
        default:    waitDrained();
      endcase
    end
    repeat (10) @(posedge pclk);
    if (expQ.size() != 0) begin
      stopWithFailure($sformatf("%0d expected bytes never appeared", expQ.size()));
    end
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      stopWithFailure("errors were recorded during the run");
    end
  end

endmodule

//--- verification/edgeTests.txt
# frame N then N rows of 18 rgb565 pixels, hex
# cmd OP DATA EXPECTED (hex), expect N then N bytes (hex), hold, release, wait
# output still off after reset, so this frame must give no bytes
frame 5
0000 0000 0000 0000 0000 0000 0000 0000 0000 FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
0000 0000 0000 0000 0000 0000 0000 0000 0000 FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
cmd 0 0 12
cmd 1 0 5
cmd 2 1 0
# vertical step at column 9, horizontal step at line 3
expect 12 55 57 80 00 55 55 00 00 00 00 00 00
frame 5
0000 0000 0000 0000 0000 0000 0000 0000 0000 FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
0000 0000 0000 0000 0000 0000 0000 0000 0000 FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
wait
# no credits back: line 4 stalls, line 5 is dropped and sets overrun
hold
expect 8 55 57 80 00 55 55 00 00
frame 5
0000 0000 0000 0000 0000 0000 0000 0000 0000 FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
0000 0000 0000 0000 0000 0000 0000 0000 0000 FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
release
wait
cmd 3 0 1
cmd 3 0 0
# uniform gray frame
expect 12 00 00 00 00 00 00 00 00 00 00 00 00
frame 5
7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF
7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF
7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF
7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF
7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF 7BEF
wait

//--- build.f
+incdir+src
src/edgePkg.sv
src/pixelIf.sv
src/cameraCapture.sv
src/lineStrip.sv
src/edgeKernel.sv
src/edgePacker.sv
src/controlRegs.sv
src/edgeDetect.sv
verification/edgeDetectTb.sv

//--- run.sh
#!/bin/sh
# compile and run the edge detector testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module edgeDetectTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/VedgeDetectTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation returned status $simStatus"
  exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
  exit 0
fi
exit 1
